// ==== rv64_int_pipe.f ====
src/rv64_pkg.sv
src/decode_if.sv
src/writeback_if.sv
src/inst_decoder.sv
src/register_file.sv
src/alu_execute.sv
src/rv64_int_pipe.sv
tests/rv64_int_pipe_tb.sv

// ==== src/alu_execute.sv ====
// Execute stage
// Operand forwarding from writeback, 64-bit and W-form ALU,
// and the writeback register

module alu_execute (
    input  logic                  clk_i,
    input  logic                  reset_i,
    decode_if.execute_mp          dec,
    writeback_if.source_mp        wb,
    writeback_if.sink_mp          wb_fwd
);

    ////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////

    // Previous instruction sits in the writeback register
    logic fwd_live;
    logic fwd_a, fwd_b;

    assign fwd_live = wb_fwd.valid && wb_fwd.wr_en;
    assign fwd_a    = fwd_live && dec.a_from_rs1 && (wb_fwd.rd_idx == dec.rs1_idx);
    assign fwd_b    = fwd_live && dec.b_from_rs2 && (wb_fwd.rd_idx == dec.rs2_idx);

    rv64_pkg::xlen_t opa, opb;

    assign opa = fwd_a ? wb_fwd.rd_data : dec.op_a;
    assign opb = fwd_b ? wb_fwd.rd_data : dec.op_b;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    // Shift amount is 5 bits for W forms
    logic [5:0] shamt;

    assign shamt = dec.word_op ? {1'b0, opb[4:0]} : opb[5:0];

    // Right-shift sources use the low word for W forms
    rv64_pkg::xlen_t srl_src, sra_src;

    assign srl_src = dec.word_op ? {32'b0, opa[31:0]} : opa;
    assign sra_src = dec.word_op ? rv64_pkg::sext32(opa[31:0]) : opa;

    rv64_pkg::xlen_t alu_res;
    rv64_pkg::xlen_t result;

    always_comb begin
        case (dec.alu_op)
            rv64_pkg::ALU_ADD:  alu_res = opa + opb;
            rv64_pkg::ALU_SUB:  alu_res = opa - opb;
            rv64_pkg::ALU_SLL:  alu_res = opa << shamt;
            rv64_pkg::ALU_SLT:  alu_res = {63'b0, $signed(opa) < $signed(opb)};
            rv64_pkg::ALU_SLTU: alu_res = {63'b0, opa < opb};
            rv64_pkg::ALU_XOR:  alu_res = opa ^ opb;
            rv64_pkg::ALU_SRL:  alu_res = srl_src >> shamt;
            rv64_pkg::ALU_SRA:  alu_res = $signed(sra_src) >>> shamt;
            rv64_pkg::ALU_OR:   alu_res = opa | opb;
            rv64_pkg::ALU_AND:  alu_res = opa & opb;
            default:            alu_res = '0;
        endcase
    end

    // W forms keep the low word, sign-extended
    assign result = dec.word_op ? rv64_pkg::sext32(alu_res[31:0]) : alu_res;

    ////////////////////////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////////////////////////

    // Control
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb.valid <= 1'b0;
            wb.wr_en <= 1'b0;
        end else begin
            wb.valid <= dec.valid;
            wb.wr_en <= dec.valid && dec.rd_wr_en;
        end
    end

    // Payload holds between instructions
    always_ff @(posedge clk_i) begin
        if (dec.valid) begin
            wb.rd_idx  <= dec.rd_idx;
            wb.rd_data <= result;
        end
    end

    // Decode raises a register write only for a valid entry with nonzero rd
    a_wr_en_needs_valid : assert property (@(posedge clk_i) disable iff (reset_i)
        dec.rd_wr_en |-> dec.valid && dec.rd_idx != '0)
        else $error("decode write enable without a valid entry or with rd x0");

endmodule

// ==== src/decode_if.sv ====
// Decode to execute bus
// One registered operation per valid strobe, operands already read

interface decode_if ();

    // Strobe, one cycle per instruction
    logic               valid;
    // Operation controls
    rv64_pkg::alu_op_e  alu_op;
    logic               word_op;
    // Destination
    rv64_pkg::reg_idx_t rd_idx;
    logic               rd_wr_en;
    // Source indices, kept for forwarding compares
    rv64_pkg::reg_idx_t rs1_idx;
    rv64_pkg::reg_idx_t rs2_idx;
    // Operand values as read or built in decode
    rv64_pkg::xlen_t    op_a;
    rv64_pkg::xlen_t    op_b;
    // Operand came from the register file
    logic               a_from_rs1;
    logic               b_from_rs2;

    modport decoder_mp (
        output valid, alu_op, word_op, rd_idx, rd_wr_en,
        output rs1_idx, rs2_idx, op_a, op_b, a_from_rs1, b_from_rs2
    );

    modport execute_mp (
        input valid, alu_op, word_op, rd_idx, rd_wr_en,
        input rs1_idx, rs2_idx, op_a, op_b, a_from_rs1, b_from_rs2
    );

endinterface

// ==== src/inst_decoder.sv ====
// Instruction decoder with register read
// Splits the strobed word, builds immediates, picks the ALU op
// and registers everything into the decode bus

module inst_decoder (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  inst_valid_i,
    input  rv64_pkg::inst_t       inst_i,
    output rv64_pkg::reg_idx_t    rs1_idx_o,
    output rv64_pkg::reg_idx_t    rs2_idx_o,
    input  rv64_pkg::xlen_t       rs1_data_i,
    input  rv64_pkg::xlen_t       rs2_data_i,
    decode_if.decoder_mp          dec
);

    ////////////////////////////////////////////////////////////
    // Field split
    ////////////////////////////////////////////////////////////

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv64_pkg::reg_idx_t rd_idx;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_idx = inst_i[11:7];

    // Register file read in the same cycle
    assign rs1_idx_o = inst_i[19:15];
    assign rs2_idx_o = inst_i[24:20];

    // Group flags
    logic is_op, is_op_imm, is_op_32, is_op_imm_32, is_lui;
    logic kept, is_reg, is_shift;

    assign is_op        = (opcode == rv64_pkg::OPC_OP);
    assign is_op_imm    = (opcode == rv64_pkg::OPC_OP_IMM);
    assign is_op_32     = (opcode == rv64_pkg::OPC_OP_32);
    assign is_op_imm_32 = (opcode == rv64_pkg::OPC_OP_IMM_32);
    assign is_lui       = (opcode == rv64_pkg::OPC_LUI);

    assign kept     = is_op | is_op_imm | is_op_32 | is_op_imm_32 | is_lui;
    assign is_reg   = is_op | is_op_32;
    assign is_shift = (funct3 == rv64_pkg::F3_SLL) || (funct3 == rv64_pkg::F3_SRL_SRA);

    ////////////////////////////////////////////////////////////
    // Immediate and ALU op
    ////////////////////////////////////////////////////////////

    rv64_pkg::xlen_t   imm;
    rv64_pkg::alu_op_e alu_op;

    always_comb begin
        // I-type by default
        imm = {{52{inst_i[31]}}, inst_i[31:20]};
        if (is_lui) begin
            imm = rv64_pkg::sext32({inst_i[31:12], 12'b0});
        end else if (is_shift && is_op_imm_32) begin
            // W shifts take 5 bits
            imm = {59'b0, inst_i[24:20]};
        end else if (is_shift) begin
            imm = {58'b0, inst_i[25:20]};
        end
    end

    always_comb begin
        alu_op = rv64_pkg::ALU_ADD;
        case (funct3)
            rv64_pkg::F3_ADD_SUB: begin
                // Immediate forms have no subtract
                if (is_reg && funct7 == rv64_pkg::F7_ALT) begin
                    alu_op = rv64_pkg::ALU_SUB;
                end
            end
            rv64_pkg::F3_SLL:  alu_op = rv64_pkg::ALU_SLL;
            rv64_pkg::F3_SLT:  alu_op = rv64_pkg::ALU_SLT;
            rv64_pkg::F3_SLTU: alu_op = rv64_pkg::ALU_SLTU;
            rv64_pkg::F3_XOR:  alu_op = rv64_pkg::ALU_XOR;
            rv64_pkg::F3_SRL_SRA: begin
                // Bit 25 is shamt[5] in the 64-bit immediate form
                if (funct7[6:1] == rv64_pkg::F7_ALT[6:1]) begin
                    alu_op = rv64_pkg::ALU_SRA;
                end else begin
                    alu_op = rv64_pkg::ALU_SRL;
                end
            end
            rv64_pkg::F3_OR:   alu_op = rv64_pkg::ALU_OR;
            rv64_pkg::F3_AND:  alu_op = rv64_pkg::ALU_AND;
            default:           alu_op = rv64_pkg::ALU_ADD;
        endcase
        // LUI is zero plus the U immediate
        if (is_lui) begin
            alu_op = rv64_pkg::ALU_ADD;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////////////////////////

    // Control
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec.valid    <= 1'b0;
            dec.rd_wr_en <= 1'b0;
        end else begin
            dec.valid    <= inst_valid_i;
            dec.rd_wr_en <= inst_valid_i && kept && (rd_idx != '0);
        end
    end

    // Payload loads on a strobe only
    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            dec.alu_op     <= alu_op;
            dec.word_op    <= is_op_32 | is_op_imm_32;
            dec.rd_idx     <= rd_idx;
            dec.rs1_idx    <= rs1_idx_o;
            dec.rs2_idx    <= rs2_idx_o;
            dec.a_from_rs1 <= kept && !is_lui;
            dec.b_from_rs2 <= is_reg;
            dec.op_a       <= is_lui ? '0 : rs1_data_i;
            dec.op_b       <= is_reg ? rs2_data_i : imm;
        end
    end

    // A strobed instruction word must be fully driven
    a_inst_known : assert property (@(posedge clk_i) disable iff (reset_i)
        inst_valid_i |-> !$isunknown(inst_i))
        else $error("unknown bits in strobed instruction word");

endmodule

// ==== src/register_file.sv ====
// Integer register file
// 31 writable registers, x0 tied to zero, two combinational reads
// with write-through of the value being written

module register_file (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  rv64_pkg::reg_idx_t    rs1_idx_i,
    input  rv64_pkg::reg_idx_t    rs2_idx_i,
    output rv64_pkg::xlen_t       rs1_data_o,
    output rv64_pkg::xlen_t       rs2_data_o,
    writeback_if.sink_mp          wb
);

    // x0 has no storage
    rv64_pkg::xlen_t regs [1:31];

    logic wr_fire;

    assign wr_fire = wb.valid && wb.wr_en;

    // Write port
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && wb.rd_idx != '0) begin
            regs[wb.rd_idx] <= wb.rd_data;
        end
    end

    // Read ports
    // Bypass covers a producer two instructions ahead
    always_comb begin
        if (rs1_idx_i == '0) begin
            rs1_data_o = '0;
        end else if (wr_fire && wb.rd_idx == rs1_idx_i) begin
            rs1_data_o = wb.rd_data;
        end else begin
            rs1_data_o = regs[rs1_idx_i];
        end
    end

    always_comb begin
        if (rs2_idx_i == '0) begin
            rs2_data_o = '0;
        end else if (wr_fire && wb.rd_idx == rs2_idx_i) begin
            rs2_data_o = wb.rd_data;
        end else begin
            rs2_data_o = regs[rs2_idx_i];
        end
    end

    // Decode must never enable a write to x0
    a_no_x0_write : assert property (@(posedge clk_i) disable iff (reset_i)
        wr_fire |-> wb.rd_idx != '0)
        else $error("write enable asserted for x0");

endmodule

// ==== src/rv64_int_pipe.sv ====
// Three-stage RV64I integer pipeline, top level
// Decode with register read, execute, writeback to plain ports

module rv64_int_pipe (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  inst_valid_i,
    input  rv64_pkg::inst_t       inst_i,
    output logic                  wb_valid_o,
    output logic                  wb_wr_en_o,
    output rv64_pkg::reg_idx_t    wb_rd_idx_o,
    output rv64_pkg::xlen_t       wb_rd_data_o
);

    ////////////////////////////////////////////////////////////
    // Stage buses and register read ports
    ////////////////////////////////////////////////////////////

    decode_if    dec_bus ();
    writeback_if wb_bus ();

    rv64_pkg::reg_idx_t rs1_idx, rs2_idx;
    rv64_pkg::xlen_t    rs1_data, rs2_data;

    // Decode and register read side by side
    inst_decoder u_inst_decoder (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .dec          (dec_bus.decoder_mp)
    );

    register_file u_register_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb         (wb_bus.sink_mp)
    );

    // Execute drives the bus and forwards from it
    alu_execute u_alu_execute (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .dec     (dec_bus.execute_mp),
        .wb      (wb_bus.source_mp),
        .wb_fwd  (wb_bus.sink_mp)
    );

    // Writeback observation ports
    assign wb_valid_o   = wb_bus.valid;
    assign wb_wr_en_o   = wb_bus.wr_en;
    assign wb_rd_idx_o  = wb_bus.rd_idx;
    assign wb_rd_data_o = wb_bus.rd_data;

endmodule

// ==== src/rv64_pkg.sv ====
// RV64 integer pipeline package
// Widths, instruction encodings, ALU operations and shared helpers

package rv64_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////////////////////////

    localparam int XLEN = 64;

    // Register value, register index, raw instruction word
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     inst_t;

    // ALU operations, shared by decode and execute
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Major opcodes of the kept groups
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Alternate funct7, selects sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // Sign extension of a word to register width
    function automatic xlen_t sext32(input logic [31:0] val);
        return {{(XLEN-32){val[31]}}, val};
    endfunction

endpackage

// ==== src/writeback_if.sv ====
// Writeback bus
// Result of execute, written into the register file and forwarded

interface writeback_if ();

    // One pulse per retired instruction
    logic               valid;
    // Register write enable, low for x0 and unknown encodings
    logic               wr_en;
    rv64_pkg::reg_idx_t rd_idx;
    rv64_pkg::xlen_t    rd_data;

    // Execute drives the bus
    modport source_mp (
        output valid, wr_en, rd_idx, rd_data
    );

    // Register file and forwarding path listen
    modport sink_mp (
        input valid, wr_en, rd_idx, rd_data
    );

endinterface

// ==== tests/rv64_int_pipe_tb.sv ====
// Testbench for the three-stage RV64I integer pipeline
// Random instruction stream with dependencies, checked against an
// architectural register model and the two-cycle writeback timing

module rv64_int_pipe_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_INSTR       = 500;
    // Worst case is three idle cycles plus the strobe per instruction
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 4 + 100;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    logic        wb_wr_en;
    logic [4:0]  wb_rd_idx;
    logic [63:0] wb_rd_data;

    // Architectural state of the model
    logic [63:0] ref_regs [0:31];
    logic [31:0] lcg_state;
    int          error_count;
    int          strobe_count;
    int          pulse_count;
    int          neg_cycle;

    // Expected writebacks with the oldest first
    logic        exp_wr_en_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [63:0] exp_data_q [$];
    logic        exp_known_q [$];
    int          exp_due_q [$];

    rv64_int_pipe rv64_int_pipe_i (
        .clk_i        (clk),
        .reset_i      (reset),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .wb_valid_o   (wb_valid),
        .wb_wr_en_o   (wb_wr_en),
        .wb_rd_idx_o  (wb_rd_idx),
        .wb_rd_data_o (wb_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random source and instruction builder
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] sign_extend_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic [31:0] build_instruction();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [6:0]  opc;
        logic        alt;
        r   = lcg_next();
        r2  = lcg_next();
        // Indices 0 to 7 so producers and consumers collide often
        rd  = {2'b0, r[18:16]};
        rs1 = {2'b0, r[21:19]};
        rs2 = {2'b0, r[24:22]};
        f3  = r[27:25];
        alt = r[28];
        case (r[31:29])
            3'd0, 3'd1: begin
                f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
                return {f7, rs2, rs1, f3, rd, rv64_pkg::OPC_OP};
            end
            3'd4: begin
                // Only add, sub and shifts exist in OP-32
                f3 = (r[26:25] == 2'd0) ? 3'b000 : (r[26:25] == 2'd1) ? 3'b001 : 3'b101;
                f7 = (alt && f3 != 3'b001) ? 7'b0100000 : 7'b0;
                return {f7, rs2, rs1, f3, rd, rv64_pkg::OPC_OP_32};
            end
            3'd5: begin
                f3 = (r[26:25] == 2'd0) ? 3'b000 : (r[26:25] == 2'd1) ? 3'b001 : 3'b101;
                if (f3 == 3'b000) begin
                    imm12 = r2[31:20];
                end else begin
                    // 5-bit shift amount
                    imm12 = {1'b0, alt && f3 == 3'b101, 5'b0, r2[31:27]};
                end
                return {imm12, rs1, f3, rd, rv64_pkg::OPC_OP_IMM_32};
            end
            3'd6: begin
                return {r2[31:12], rd, rv64_pkg::OPC_LUI};
            end
            3'd7: begin
                if (r2[31]) begin
                    // Load, store, branch and jal encodings
                    case (r2[17:16])
                        2'd0:    opc = 7'b0000011;
                        2'd1:    opc = 7'b0100011;
                        2'd2:    opc = 7'b1100011;
                        default: opc = 7'b1101111;
                    endcase
                    return {r2[31:12], rd, opc};
                end
            end
            default: ;
        endcase
        // OP-IMM with a 6-bit shift amount for shifts
        if (f3 == 3'b001) begin
            imm12 = {6'b0, r2[31:26]};
        end else if (f3 == 3'b101) begin
            imm12 = {1'b0, alt, 4'b0, r2[31:26]};
        end else begin
            imm12 = r2[31:20];
        end
        return {imm12, rs1, f3, rd, rv64_pkg::OPC_OP_IMM};
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    task automatic ref_execute(input logic [31:0] ins, output logic wr_en,
                               output logic [63:0] data, output logic known);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic        alt;
        logic [63:0] a;
        logic [63:0] src2;
        logic [31:0] w;
        opc   = ins[6:0];
        f3    = ins[14:12];
        rd    = ins[11:7];
        alt   = ins[30];
        a     = ref_regs[ins[19:15]];
        known = 1'b1;
        data  = '0;
        // Second source is rs2 for register forms and the I immediate otherwise
        if (opc == rv64_pkg::OPC_OP || opc == rv64_pkg::OPC_OP_32) begin
            src2 = ref_regs[ins[24:20]];
        end else begin
            src2 = {{52{ins[31]}}, ins[31:20]};
        end
        case (opc)
            rv64_pkg::OPC_OP, rv64_pkg::OPC_OP_IMM: begin
                case (f3)
                    3'b000: begin
                        if (opc == rv64_pkg::OPC_OP && alt) data = a - src2;
                        else data = a + src2;
                    end
                    3'b001: data = a << src2[5:0];
                    3'b010: data = ($signed(a) < $signed(src2)) ? 64'd1 : 64'd0;
                    3'b011: data = (a < src2) ? 64'd1 : 64'd0;
                    3'b100: data = a ^ src2;
                    3'b101: begin
                        if (alt) data = $signed(a) >>> src2[5:0];
                        else data = a >> src2[5:0];
                    end
                    3'b110: data = a | src2;
                    default: data = a & src2;
                endcase
            end
            rv64_pkg::OPC_OP_32, rv64_pkg::OPC_OP_IMM_32: begin
                // Word forms work on the low 32 bits
                case (f3)
                    3'b001: w = a[31:0] << src2[4:0];
                    3'b101: begin
                        if (alt) w = $signed(a[31:0]) >>> src2[4:0];
                        else w = a[31:0] >> src2[4:0];
                    end
                    default: begin
                        if (opc == rv64_pkg::OPC_OP_32 && alt) w = a[31:0] - src2[31:0];
                        else w = a[31:0] + src2[31:0];
                    end
                endcase
                data = sign_extend_word(w);
            end
            rv64_pkg::OPC_LUI: data = sign_extend_word({ins[31:12], 12'b0});
            default: known = 1'b0;
        endcase
        wr_en = known && (rd != 5'd0);
        if (wr_en) begin
            ref_regs[rd] = data;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Writeback monitor sampled on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : wb_monitor
        logic        exp_wr;
        logic [4:0]  exp_rd;
        logic [63:0] exp_data;
        logic        exp_known;
        int          exp_due;
        logic        new_wr;
        logic [63:0] new_data;
        logic        new_known;
        neg_cycle++;
        if (reset) begin
            assert (!wb_valid && !wb_wr_en) else begin
                error_count++;
                $display("Writeback outputs not low during reset at %0t", $time);
            end
        end else begin
            // A pulse that is overdue never came
            assert (exp_due_q.size() == 0 || exp_due_q[0] >= neg_cycle) else begin
                error_count++;
                $display("Writeback pulse missing at %0t for rd %0d", $time, exp_rd_q[0]);
                void'(exp_wr_en_q.pop_front());
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_known_q.pop_front());
                void'(exp_due_q.pop_front());
            end
            if (wb_valid) begin
                pulse_count++;
                assert (exp_due_q.size() != 0) else begin
                    error_count++;
                    $display("Writeback pulse without a strobe at %0t", $time);
                end
                if (exp_due_q.size() != 0) begin
                    exp_wr    = exp_wr_en_q.pop_front();
                    exp_rd    = exp_rd_q.pop_front();
                    exp_data  = exp_data_q.pop_front();
                    exp_known = exp_known_q.pop_front();
                    exp_due   = exp_due_q.pop_front();
                    assert (exp_due == neg_cycle) else begin
                        error_count++;
                        $display("Writeback pulse at %0t not two cycles after its strobe",
                                 $time);
                    end
                    assert (wb_wr_en == exp_wr) else begin
                        error_count++;
                        $display("Mismatch at %0t: wb_wr_en_o got %0b expected %0b",
                                 $time, wb_wr_en, exp_wr);
                    end
                    assert (wb_rd_idx == exp_rd) else begin
                        error_count++;
                        $display("Mismatch at %0t: wb_rd_idx_o got %0d expected %0d",
                                 $time, wb_rd_idx, exp_rd);
                    end
                    // Unknown encodings carry no defined result
                    assert (!exp_known || wb_rd_data == exp_data) else begin
                        error_count++;
                        $display("Mismatch at %0t: wb_rd_data_o got %h expected %h",
                                 $time, wb_rd_data, exp_data);
                    end
                end
            end else begin
                assert (!wb_wr_en) else begin
                    error_count++;
                    $display("Write enable high without a writeback pulse at %0t", $time);
                end
            end
            // Model runs in strobe order
            if (inst_valid) begin
                strobe_count++;
                ref_execute(inst, new_wr, new_data, new_known);
                exp_wr_en_q.push_back(new_wr);
                exp_rd_q.push_back(inst[11:7]);
                exp_data_q.push_back(new_data);
                exp_known_q.push_back(new_known);
                exp_due_q.push_back(neg_cycle + 2);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          idle;
        lcg_state    = 32'h6ca6_4a97;
        error_count  = 0;
        strobe_count = 0;
        pulse_count  = 0;
        neg_cycle    = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            // Half the strobes come back to back
            r    = lcg_next();
            idle = r[31] ? int'(r[30:29]) : 0;
            repeat (idle) begin
                @(posedge clk);
                inst_valid <= 1'b0;
            end
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= build_instruction();
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        // Drain the pipeline until every expected writeback is seen
        while (exp_due_q.size() != 0) begin
            @(posedge clk);
        end
        // Catch any stray pulse
        repeat (3) @(posedge clk);
        $display("Strobes %0d, writebacks %0d, errors %0d",
                 strobe_count, pulse_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all writebacks arrived");
        $display("Strobes %0d, writebacks %0d, errors %0d",
                 strobe_count, pulse_count, error_count + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule
